/* logic/tri_pkg.sv */
package tri_pkg;

	// Register offsets on the APB port
	localparam logic [4:0] addr_lin_ctrl = 5'h08;
	localparam logic [4:0] addr_timer_lo = 5'h0A;
	localparam logic [4:0] addr_timer_hi = 5'h0B;
	localparam logic [4:0] addr_status   = 5'h15;
	localparam logic [4:0] addr_test     = 5'h1A;

	localparam int seq_bits = 5;

	// Linear counter control byte, bit 7 doubles as length halt
	typedef struct packed {
		logic       halt;
		logic [6:0] lin_reload;
	} tri_lin_ctrl_t;

	typedef struct packed {
		logic [4:0] len_index;
		logic [2:0] period_hi;
	} tri_timer_hi_t;

	// Same write byte, decoded per target register
	typedef union packed {
		logic [7:0]    raw;
		tri_lin_ctrl_t lin_ctrl;
		tri_timer_hi_t timer_hi;
	} tri_wdata_u;

	typedef struct packed {
		logic        halt;
		logic [6:0]  lin_reload;
		logic [10:0] period;
		logic [4:0]  len_index;
	} tri_regs_t;

	// One-cycle strobes, high in the cycle after the APB write edge
	typedef struct packed {
		logic lin_ctrl;
		logic timer_lo;
		logic timer_hi;
		logic test;
	} tri_wr_t;

	localparam logic [7:0] length_table [32] = '{
		8'd10,
		8'd254,
		8'd20,
		8'd2,
		8'd40,
		8'd4,
		8'd80,
		8'd6,
		8'd160,
		8'd8,
		8'd60,
		8'd10,
		8'd14,
		8'd12,
		8'd26,
		8'd14,
		8'd12,
		8'd16,
		8'd24,
		8'd18,
		8'd48,
		8'd20,
		8'd96,
		8'd22,
		8'd192,
		8'd24,
		8'd72,
		8'd26,
		8'd16,
		8'd28,
		8'd32,
		8'd30
	};

endpackage

/* logic/tri_apb_regs.sv */
`timescale 1ns/1ps

module tri_apb_regs (
	input  logic               phi1,
	input  logic               rst_n,
	input  logic               psel,
	input  logic               penable,
	input  logic               pwrite,
	input  logic [4:0]         paddr,
	input  logic [7:0]         pwdata,
	output logic [7:0]         prdata,
	output logic               pready,
	input  logic               length_nonzero,
	output tri_pkg::tri_regs_t regs,
	output tri_pkg::tri_wr_t   wr,
	output logic [4:0]         seq_load,
	output logic               len_enable
);

	tri_pkg::tri_wdata_u wdata;
	logic apb_wr;
	logic wr_lin_ctrl;
	logic wr_timer_lo;
	logic wr_timer_hi;
	logic wr_status;
	logic wr_test;

	assign wdata = pwdata;

	// No wait states
	assign pready = 1'b1;
	assign apb_wr = psel & penable & pwrite;

	assign wr_lin_ctrl = apb_wr & (paddr == tri_pkg::addr_lin_ctrl);
	assign wr_timer_lo = apb_wr & (paddr == tri_pkg::addr_timer_lo);
	assign wr_timer_hi = apb_wr & (paddr == tri_pkg::addr_timer_hi);
	assign wr_status   = apb_wr & (paddr == tri_pkg::addr_status);
	assign wr_test     = apb_wr & (paddr == tri_pkg::addr_test);

	always_ff @(posedge phi1 or negedge rst_n) begin
		if (!rst_n) begin
			regs       <= '0;
			wr         <= '0;
			seq_load   <= '0;
			len_enable <= 1'b0;
		end else begin
			wr.lin_ctrl <= wr_lin_ctrl;
			wr.timer_lo <= wr_timer_lo;
			wr.timer_hi <= wr_timer_hi;
			wr.test     <= wr_test;
			if (wr_lin_ctrl) begin
				regs.halt       <= wdata.lin_ctrl.halt;
				regs.lin_reload <= wdata.lin_ctrl.lin_reload;
			end
			if (wr_timer_lo) begin
				regs.period[7:0] <= wdata.raw;
			end
			if (wr_timer_hi) begin
				regs.period[10:8] <= wdata.timer_hi.period_hi;
				regs.len_index    <= wdata.timer_hi.len_index;
			end
			if (wr_status) begin
				len_enable <= wdata.raw[2];
			end
			if (wr_test) begin
				seq_load <= wdata.raw[4:0];
			end
		end
	end

	always_comb begin
		prdata = 8'h00;
		if (psel && !pwrite && paddr == tri_pkg::addr_status) begin
			prdata[2] = length_nonzero;
		end
	end

endmodule

/* logic/tri_linear_counter.sv */
`timescale 1ns/1ps

module tri_linear_counter (
	input  logic               phi1,
	input  logic               rst_n,
	input  tri_pkg::tri_regs_t regs,
	input  tri_pkg::tri_wr_t   wr,
	input  logic               quarter_frame,
	output logic               linear_nonzero
);

	logic [6:0] cnt;
	logic       reload_flag;

	always_ff @(posedge phi1 or negedge rst_n) begin
		if (!rst_n) begin
			cnt <= 7'd0;
		end else if (quarter_frame) begin
			if (reload_flag) begin
				cnt <= regs.lin_reload;
			end else if (cnt != 7'd0) begin
				cnt <= cnt - 7'd1;
			end
		end
	end

	// Set by timer high write, dropped after a tick unless control bit holds it
	always_ff @(posedge phi1 or negedge rst_n) begin
		if (!rst_n) begin
			reload_flag <= 1'b0;
		end else if (wr.timer_hi) begin
			reload_flag <= 1'b1;
		end else if (quarter_frame && !regs.halt) begin
			reload_flag <= 1'b0;
		end
	end

	assign linear_nonzero = (cnt != 7'd0);

endmodule

/* logic/tri_length_counter.sv */
`timescale 1ns/1ps

module tri_length_counter (
	input  logic               phi1,
	input  logic               rst_n,
	input  tri_pkg::tri_regs_t regs,
	input  tri_pkg::tri_wr_t   wr,
	input  logic               len_enable,
	input  logic               half_frame,
	output logic               length_nonzero
);

	logic [7:0] cnt;
	logic [7:0] load_value;

	assign load_value = tri_pkg::length_table[regs.len_index];

	always_ff @(posedge phi1 or negedge rst_n) begin
		if (!rst_n) begin
			cnt <= 8'd0;
		end else if (!len_enable) begin
			// Disabled channel holds the counter at zero
			cnt <= 8'd0;
		end else if (wr.timer_hi) begin
			cnt <= load_value;
		end else if (half_frame && !regs.halt && cnt != 8'd0) begin
			cnt <= cnt - 8'd1;
		end
	end

	assign length_nonzero = (cnt != 8'd0);

endmodule

/* logic/tri_timer.sv */
`timescale 1ns/1ps

module tri_timer (
	input  logic               phi1,
	input  logic               rst_n,
	input  tri_pkg::tri_regs_t regs,
	input  tri_pkg::tri_wr_t   wr,
	output logic               step
);

	logic [10:0] cnt;

	// Period+1 cycles between steps
	always_ff @(posedge phi1 or negedge rst_n) begin
		if (!rst_n) begin
			cnt  <= 11'd0;
			step <= 1'b0;
		end else if (wr.timer_hi) begin
			cnt  <= regs.period;
			step <= 1'b0;
		end else if (cnt == 11'd0) begin
			cnt  <= regs.period;
			step <= 1'b1;
		end else begin
			cnt  <= cnt - 11'd1;
			step <= 1'b0;
		end
	end

endmodule

/* logic/tri_sequencer.sv */
`timescale 1ns/1ps

module tri_sequencer (
	input  logic                         phi1,
	input  logic                         rst_n,
	input  logic                         step,
	input  logic                         linear_nonzero,
	input  logic                         length_nonzero,
	input  tri_pkg::tri_wr_t             wr,
	input  logic [tri_pkg::seq_bits-1:0] seq_load,
	output logic [3:0]                   tri_out
);

	logic [tri_pkg::seq_bits-1:0] cnt;
	logic                         advance;

	assign advance = step & linear_nonzero & length_nonzero;

	always_ff @(posedge phi1 or negedge rst_n) begin
		if (!rst_n) begin
			cnt <= '0;
		end else if (wr.test) begin
			cnt <= seq_load;
		end else if (advance) begin
			cnt <= cnt + 1'b1;
		end
	end

	// First half falls 15..0, second half rises 0..15
	assign tri_out = cnt[tri_pkg::seq_bits-1] ? cnt[3:0] : ~cnt[3:0];

endmodule

/* logic/tri_channel.sv */
`timescale 1ns/1ps

module tri_channel (
	input  logic       phi1,
	input  logic       rst_n,
	input  logic       psel,
	input  logic       penable,
	input  logic       pwrite,
	input  logic [4:0] paddr,
	input  logic [7:0] pwdata,
	output logic [7:0] prdata,
	output logic       pready,
	input  logic       quarter_frame,
	input  logic       half_frame,
	output logic [3:0] tri_out
);

	tri_pkg::tri_regs_t regs;
	tri_pkg::tri_wr_t   wr;
	logic [4:0]         seq_load;
	logic               len_enable;
	logic               length_nonzero;
	logic               linear_nonzero;
	logic               step;

	tri_apb_regs u_regs (
		.phi1           (phi1),
		.rst_n          (rst_n),
		.psel           (psel),
		.penable        (penable),
		.pwrite         (pwrite),
		.paddr          (paddr),
		.pwdata         (pwdata),
		.prdata         (prdata),
		.pready         (pready),
		.length_nonzero (length_nonzero),
		.regs           (regs),
		.wr             (wr),
		.seq_load       (seq_load),
		.len_enable     (len_enable)
	);

	tri_linear_counter u_lin_cnt (
		.phi1           (phi1),
		.rst_n          (rst_n),
		.regs           (regs),
		.wr             (wr),
		.quarter_frame  (quarter_frame),
		.linear_nonzero (linear_nonzero)
	);

	tri_length_counter u_len_cnt (
		.phi1           (phi1),
		.rst_n          (rst_n),
		.regs           (regs),
		.wr             (wr),
		.len_enable     (len_enable),
		.half_frame     (half_frame),
		.length_nonzero (length_nonzero)
	);

	tri_timer u_timer (
		.phi1  (phi1),
		.rst_n (rst_n),
		.regs  (regs),
		.wr    (wr),
		.step  (step)
	);

	tri_sequencer u_seq (
		.phi1           (phi1),
		.rst_n          (rst_n),
		.step           (step),
		.linear_nonzero (linear_nonzero),
		.length_nonzero (length_nonzero),
		.wr             (wr),
		.seq_load       (seq_load),
		.tri_out        (tri_out)
	);

endmodule

/* tests/tri_channel_tb.sv */
`timescale 1ns/1ps

module tri_channel_tb;

	localparam int clk_period = 10;
	localparam int max_period = 31;

	// Rough cycle budget per test
	localparam int reset_test_cycles = 50;
	localparam int length_test_cycles = 2 * 256 + 100;
	localparam int waveform_test_cycles = 34 * (max_period + 1) + 100;
	localparam int gating_test_cycles = 8 * (max_period + 1) + 200;
	localparam int test_reg_cycles = 32 * 10 + 50;
	localparam int watchdog_cycles = 2 * (reset_test_cycles + length_test_cycles +
		waveform_test_cycles + gating_test_cycles + test_reg_cycles) + 200;

	// Standard length counter load values
	localparam int len_values [32] = '{
		10, 254, 20, 2, 40, 4, 80, 6,
		160, 8, 60, 10, 14, 12, 26, 14,
		12, 16, 24, 18, 48, 20, 96, 22,
		192, 24, 72, 26, 16, 28, 32, 30
	};

	logic        phi1 = 1'b0;
	logic        rst_n;
	logic        psel;
	logic        penable;
	logic        pwrite;
	logic [4:0]  paddr;
	logic [7:0]  pwdata;
	logic [7:0]  prdata;
	logic        pready;
	logic        quarter_frame;
	logic        half_frame;
	logic [3:0]  tri_out;
	logic [31:0] lcg_state = 32'hf1b4b09b;
	logic [10:0] period;

	tri_channel UUT (
		.phi1          (phi1),
		.rst_n         (rst_n),
		.psel          (psel),
		.penable       (penable),
		.pwrite        (pwrite),
		.paddr         (paddr),
		.pwdata        (pwdata),
		.prdata        (prdata),
		.pready        (pready),
		.quarter_frame (quarter_frame),
		.half_frame    (half_frame),
		.tri_out       (tri_out)
	);

	always #(clk_period / 2) phi1 = ~phi1;

	function automatic logic [31:0] lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// Steps 0..15 fall from 15, steps 16..31 rise from 0
	function automatic int fold_step(input int s);
		if (s < 16) begin
			return 15 - s;
		end else begin
			return s - 16;
		end
	endfunction

	task automatic stop_run(input string what);
		$display("ERROR at %0t ns: %s", $time, what);
		$display("Some tests failed");
		$fatal(1, "Simulation stopped");
	endtask

	task automatic check_value(input string name, input int got, input int expected);
		assert (got == expected) else begin
			$display("CHECK FAILED at %0t ns: %s expected %0d, got %0d",
				$time, name, expected, got);
			stop_run("value mismatch");
		end
	endtask

	task automatic apb_write(input logic [4:0] addr, input logic [7:0] data);
		@(posedge phi1);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= 1'b1;
		paddr   <= addr;
		pwdata  <= data;
		@(posedge phi1);
		penable <= 1'b1;
		@(posedge phi1);
		psel    <= 1'b0;
		penable <= 1'b0;
		pwrite  <= 1'b0;
	endtask

	task automatic apb_read(input logic [4:0] addr, output logic [7:0] data);
		@(posedge phi1);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= 1'b0;
		paddr   <= addr;
		@(posedge phi1);
		penable <= 1'b1;
		@(negedge phi1);
		data = prdata;
		check_value("pready", pready, 1);
		@(posedge phi1);
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic pulse_quarter();
		@(posedge phi1);
		quarter_frame <= 1'b1;
		@(posedge phi1);
		quarter_frame <= 1'b0;
	endtask

	task automatic pulse_half();
		@(posedge phi1);
		half_frame <= 1'b1;
		@(posedge phi1);
		half_frame <= 1'b0;
	endtask

	// Two steps cover the flat spots at 15/16 and 31/0
	task automatic expect_moving(input string what);
		logic [3:0] first;
		logic       changed;
		@(negedge phi1);
		first = tri_out;
		changed = 1'b0;
		repeat (2 * (period + 1) + 1) begin
			@(negedge phi1);
			if (tri_out != first) begin
				changed = 1'b1;
			end
		end
		assert (changed) else begin
			stop_run(what);
		end
	endtask

	task automatic expect_frozen();
		logic [3:0] held;
		@(negedge phi1);
		held = tri_out;
		repeat (3 * (period + 1)) begin
			@(negedge phi1);
			check_value("tri_out", tri_out, held);
		end
	endtask

	task automatic test_reset();
		logic [7:0] rd;
		@(negedge phi1);
		check_value("tri_out", tri_out, 15);
		apb_read(tri_pkg::addr_status, rd);
		check_value("prdata", rd, 0);
	endtask

	task automatic test_length();
		logic [4:0] idx;
		logic [7:0] rd;
		int         count;
		idx = 5'((lcg_next() >> 16) % 32);
		count = len_values[idx];
		apb_write(tri_pkg::addr_lin_ctrl, 8'h00);
		apb_write(tri_pkg::addr_status, 8'h04);
		apb_write(tri_pkg::addr_timer_hi, {idx, 3'b000});
		apb_read(tri_pkg::addr_status, rd);
		check_value("prdata", rd, 8'h04);
		repeat (count - 1) pulse_half();
		apb_read(tri_pkg::addr_status, rd);
		check_value("prdata", rd, 8'h04);
		pulse_half();
		apb_read(tri_pkg::addr_status, rd);
		check_value("prdata", rd, 0);
		// Load attempt while disabled
		apb_write(tri_pkg::addr_status, 8'h00);
		apb_write(tri_pkg::addr_timer_hi, {idx, 3'b000});
		apb_read(tri_pkg::addr_status, rd);
		check_value("prdata", rd, 0);
	endtask

	task automatic test_waveform();
		logic [6:0] reload;
		int         waited;
		period = 11'(8 + (lcg_next() >> 16) % 24);
		reload = 7'(16 + (lcg_next() >> 16) % 100);
		apb_write(tri_pkg::addr_test, 8'h00);
		apb_write(tri_pkg::addr_lin_ctrl, {1'b0, reload});
		apb_write(tri_pkg::addr_timer_lo, period[7:0]);
		apb_write(tri_pkg::addr_status, 8'h04);
		apb_write(tri_pkg::addr_timer_hi, {5'd1, period[10:8]});
		pulse_quarter();
		@(negedge phi1);
		check_value("tri_out", tri_out, fold_step(0));
		waited = 0;
		while (tri_out == fold_step(0) && waited < period + 4) begin
			@(negedge phi1);
			waited++;
		end
		check_value("tri_out", tri_out, fold_step(1));
		for (int k = 2; k <= 33; k++) begin
			repeat (period) begin
				@(negedge phi1);
				check_value("tri_out", tri_out, fold_step((k - 1) % 32));
			end
			@(negedge phi1);
			check_value("tri_out", tri_out, fold_step(k % 32));
		end
	endtask

	task automatic test_linear_gating();
		logic [6:0] reload;
		reload = 7'(1 + (lcg_next() >> 16) % 8);
		apb_write(tri_pkg::addr_lin_ctrl, {1'b0, reload});
		apb_write(tri_pkg::addr_timer_hi, {5'd1, period[10:8]});
		// Reload, then decrement down to one
		repeat (reload) pulse_quarter();
		expect_moving("tri_out stopped before the linear counter ran out");
		pulse_quarter();
		expect_frozen();
		// Control bit keeps the reload flag set
		apb_write(tri_pkg::addr_lin_ctrl, {1'b1, reload});
		apb_write(tri_pkg::addr_timer_hi, {5'd1, period[10:8]});
		repeat (reload + 3) pulse_quarter();
		expect_moving("tri_out stopped although the linear counter control bit was set");
	endtask

	task automatic test_test_register();
		int start;
		int value;
		start = (lcg_next() >> 16) % 32;
		apb_write(tri_pkg::addr_status, 8'h00);
		for (int i = 0; i < 32; i++) begin
			value = (start + i) % 32;
			apb_write(tri_pkg::addr_test, 8'(value));
			@(negedge phi1);
			@(negedge phi1);
			check_value("tri_out", tri_out, fold_step(value));
		end
	endtask

	initial begin
		#(watchdog_cycles * clk_period);
		stop_run("timeout, the tests did not finish in the expected time");
	end

	initial begin
		rst_n = 1'b0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		quarter_frame = 1'b0;
		half_frame = 1'b0;
		period = 11'd8;
		repeat (4) @(posedge phi1);
		rst_n <= 1'b1;
		test_reset();
		test_length();
		test_waveform();
		test_linear_gating();
		test_test_register();
		$display("All tests passed");
		$finish;
	end

endmodule

/* tri_channel.f */
logic/tri_pkg.sv
logic/tri_apb_regs.sv
logic/tri_linear_counter.sv
logic/tri_length_counter.sv
logic/tri_timer.sv
logic/tri_sequencer.sv
logic/tri_channel.sv
tests/tri_channel_tb.sv
